//--- bench/experiar_soc_tb.sv
`timescale 1ns/1ps
`include "experiar_consts.svh"

module experiar_soc_tb import experiar_pkg::*; ();

	localparam int TIMEOUT_CYCLES = 50;
	localparam int NUM_TXN = 14;
	localparam int MEM_WORDS = 1 << `EXPERIAR_SRAM_ADDRESS_SIZE;

	// One row of the transaction table
	typedef struct packed {
		logic master;
		logic we;
		wb_adr_t adr;
		wb_sel_t sel;
		logic expect_err;
	} txn_t;

	logic clk;
	logic rst_n;
	wb_req_t master0_req;
	wb_req_t master1_req;
	wb_rsp_t master0_rsp;
	wb_rsp_t master1_rsp;
	gpio_t io_in;
	gpio_t io_out;
	gpio_t io_oeb;
	logic irq;
	logic [127:0] la_data;

	txn_t txn_table [NUM_TXN];
	wb_data_t model_mem [0:MEM_WORDS-1];

	experiar_soc experiar_soc_i (
		.wb_clk_i(clk), .rst_n_i(rst_n),
		.master0_req_i(master0_req), .master1_req_i(master1_req),
		.master0_rsp_o(master0_rsp), .master1_rsp_o(master1_rsp),
		.io_i(io_in), .io_o(io_out), .io_oeb_o(io_oeb),
		.irq_o(irq), .la_data_o(la_data));

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	function automatic txn_t make_txn(input logic master, input logic we, input wb_adr_t adr,
			input wb_sel_t sel, input logic expect_err);
		txn_t t;
		t.master = master;
		t.we = we;
		t.adr = adr;
		t.sel = sel;
		t.expect_err = expect_err;
		return t;
	endfunction

	// Word index from address bits 10..2 where higher bits alias
	function automatic sram_addr_t model_index(input wb_adr_t adr);
		return adr[`EXPERIAR_SRAM_ADDRESS_SIZE+1:2];
	endfunction

	function automatic wb_adr_t gpio_adr(input int offset);
		return {`EXPERIAR_SLAVE_PERIPH, 24'(offset * 4)};
	endfunction

	function automatic wb_rsp_t rsp_of(input logic master);
		return master ? master1_rsp : master0_rsp;
	endfunction

	function automatic void model_write(input wb_adr_t adr, input wb_sel_t sel,
			input wb_data_t data);
		for (int i = 0; i < 4; i++) begin
			if (sel[i]) model_mem[model_index(adr)][8*i +: 8] = data[8*i +: 8];
		end
	endfunction

	task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
			input string what);
		if (actual !== expected) begin
			$display("[ERROR] %0d ns: %s: got %h, expected %h", $time, what, actual, expected);
			$display("RESULT: FAIL");
			$fatal(1, "Stopped at the first mismatch");
		end
	endtask

	task automatic drive_req(input logic master, input wb_req_t req);
		if (master) begin
			master1_req <= req;
		end else begin
			master0_req <= req;
		end
	endtask

	// Optionally the other master must see stall on every sampled cycle
	task automatic wait_response(input logic master, input logic other_stalls,
			output wb_rsp_t rsp);
		int cycles;
		wb_rsp_t other;
		cycles = 0;
		rsp = '0;
		while (!(rsp.ack || rsp.error)) begin
			@(negedge clk);
			rsp = rsp_of(master);
			if (other_stalls) begin
				other = rsp_of(!master);
				check_value(32'(other.stall), 32'd1, "stall of the waiting master");
				check_value(32'(other.ack), 32'd0, "ack of the waiting master");
			end
			cycles++;
			if (!(rsp.ack || rsp.error) && cycles >= TIMEOUT_CYCLES) begin
				$display("Timeout: master %0d got neither ack nor error", master);
				$display("RESULT: FAIL");
				$fatal(1, "Bus response timeout");
			end
		end
	endtask

	task automatic transact(input logic master, input logic we, input wb_adr_t adr,
			input wb_sel_t sel, input wb_data_t data, output wb_rsp_t rsp);
		wb_req_t req;
		req = '0;
		req.cyc = 1'b1;
		req.stb = 1'b1;
		req.we = we;
		req.sel = sel;
		req.data = data;
		req.adr = adr;
		@(posedge clk);
		drive_req(master, req);
		wait_response(master, 1'b0, rsp);
		@(posedge clk);
		drive_req(master, '0);
	endtask

	task automatic gpio_write(input logic master, input int offset, input wb_data_t data);
		wb_rsp_t rsp;
		transact(master, 1'b1, gpio_adr(offset), 4'hf, data, rsp);
		check_value(32'(rsp.ack), 32'd1, $sformatf("ack of write to offset %0d", offset));
	endtask

	task automatic gpio_read(input logic master, input int offset, input wb_data_t expected,
			input string what);
		wb_rsp_t rsp;
		transact(master, 1'b0, gpio_adr(offset), 4'hf, '0, rsp);
		check_value(32'(rsp.ack), 32'd1, {what, " ack"});
		check_value(rsp.data, expected, what);
	endtask

	task automatic wait_irq_high();
		int cycles;
		cycles = 0;
		while (irq !== 1'b1) begin
			@(negedge clk);
			cycles++;
			if (irq !== 1'b1 && cycles >= TIMEOUT_CYCLES) begin
				$display("Timeout: irq_o never rose after an enabled pad edge");
				$display("RESULT: FAIL");
				$fatal(1, "Interrupt timeout");
			end
		end
	endtask

	task automatic check_reset_values();
		check_value(32'({master0_rsp.ack, master0_rsp.stall, master0_rsp.error}), 32'd0,
			"master 0 response after reset");
		check_value(32'({master1_rsp.ack, master1_rsp.stall, master1_rsp.error}), 32'd0,
			"master 1 response after reset");
		check_value(io_out, 32'h0, "io_o after reset");
		check_value(io_oeb, 32'hffff_ffff, "io_oeb_o after reset");
		check_value(32'(irq), 32'd0, "irq_o after reset");
		check_value(32'(|la_data), 32'd0, "la_data_o after reset");
	endtask

	task automatic load_table();
		// Full words first so later partial writes land on known bytes
		txn_table[0] = make_txn(1'b0, 1'b1, 28'h0000010, 4'hf, 1'b0);
		txn_table[1] = make_txn(1'b0, 1'b0, 28'h0000010, 4'hf, 1'b0);
		txn_table[2] = make_txn(1'b1, 1'b1, 28'h0000010, 4'h3, 1'b0);
		txn_table[3] = make_txn(1'b1, 1'b0, 28'h0000010, 4'hf, 1'b0);
		txn_table[4] = make_txn(1'b1, 1'b1, 28'h0000104, 4'hf, 1'b0);
		txn_table[5] = make_txn(1'b0, 1'b0, 28'h0abc104, 4'hf, 1'b0);
		txn_table[6] = make_txn(1'b0, 1'b1, 28'h0abc104, 4'hc, 1'b0);
		txn_table[7] = make_txn(1'b1, 1'b0, 28'h0000104, 4'hf, 1'b0);
		txn_table[8] = make_txn(1'b1, 1'b1, 28'h00007fc, 4'hf, 1'b0);
		txn_table[9] = make_txn(1'b0, 1'b0, 28'h0fffffc, 4'hf, 1'b0);
		// Unmapped regions and peripheral offsets past IRQ_STAT
		txn_table[10] = make_txn(1'b0, 1'b0, 28'h2000000, 4'hf, 1'b1);
		txn_table[11] = make_txn(1'b1, 1'b1, 28'hf000040, 4'hf, 1'b1);
		txn_table[12] = make_txn(1'b0, 1'b0, gpio_adr(5), 4'hf, 1'b1);
		txn_table[13] = make_txn(1'b1, 1'b1, gpio_adr(7), 4'hf, 1'b1);
	endtask

	task automatic run_table();
		txn_t t;
		wb_data_t data;
		wb_rsp_t rsp;
		for (int i = 0; i < NUM_TXN; i++) begin
			t = txn_table[i];
			data = t.we ? $urandom() : '0;
			transact(t.master, t.we, t.adr, t.sel, data, rsp);
			check_value(32'(rsp.error), 32'(t.expect_err), $sformatf("txn %0d error", i));
			check_value(32'(rsp.ack), 32'(!t.expect_err), $sformatf("txn %0d ack", i));
			if (!t.expect_err && t.we) begin
				model_write(t.adr, t.sel, data);
			end else if (!t.expect_err) begin
				check_value(rsp.data, model_mem[model_index(t.adr)],
					$sformatf("txn %0d read data", i));
			end
		end
	endtask

	// Master 0 writes the word that master 1 reads in the same cycle
	task automatic run_contention();
		wb_req_t req0;
		wb_req_t req1;
		wb_rsp_t rsp0;
		wb_rsp_t rsp1;
		wb_data_t wdata;
		wdata = $urandom();
		req0 = '0;
		req0.cyc = 1'b1;
		req0.stb = 1'b1;
		req0.we = 1'b1;
		req0.sel = 4'hf;
		req0.data = wdata;
		req0.adr = 28'h0000200;
		req1 = '0;
		req1.cyc = 1'b1;
		req1.stb = 1'b1;
		req1.sel = 4'hf;
		req1.adr = 28'h0400200;
		@(posedge clk);
		master0_req <= req0;
		master1_req <= req1;
		wait_response(1'b0, 1'b1, rsp0);
		check_value(32'(rsp0.ack), 32'd1, "master 0 ack under contention");
		// Both masters target memory and master 0 holds it
		check_value(la_data[31:0], 32'h15, "probes while master 0 holds memory");
		model_write(req0.adr, req0.sel, wdata);
		@(posedge clk);
		master0_req <= '0;
		wait_response(1'b1, 1'b0, rsp1);
		check_value(32'(rsp1.ack), 32'd1, "master 1 ack after master 0 released");
		check_value(rsp1.data, model_mem[model_index(req1.adr)], "master 1 read data");
		@(posedge clk);
		master1_req <= '0;
	endtask

	// Master 1 alone on the peripherals, probes sampled in the ack cycle
	task automatic run_periph_probe();
		wb_req_t req;
		wb_rsp_t rsp;
		req = '0;
		req.cyc = 1'b1;
		req.stb = 1'b1;
		req.sel = 4'hf;
		req.adr = gpio_adr(`EXPERIAR_GPIO_OUT);
		@(posedge clk);
		master1_req <= req;
		wait_response(1'b1, 1'b0, rsp);
		check_value(32'(rsp.ack), 32'd1, "ack of the peripheral probe read");
		check_value(la_data[31:0], 32'h88, "probes while master 1 holds the peripherals");
		@(posedge clk);
		master1_req <= '0;
	endtask

	task automatic run_gpio();
		wb_data_t out_val;
		wb_data_t oe_val;
		wb_data_t pad_val;
		out_val = $urandom();
		oe_val = $urandom();
		pad_val = $urandom();
		gpio_write(1'b0, `EXPERIAR_GPIO_OUT, out_val);
		check_value(io_out, out_val, "io_o after OUT write");
		gpio_write(1'b1, `EXPERIAR_GPIO_OE, oe_val);
		check_value(io_oeb, oe_val, "io_oeb_o after OE write");
		gpio_read(1'b0, `EXPERIAR_GPIO_OUT, out_val, "OUT readback");
		gpio_read(1'b1, `EXPERIAR_GPIO_OE, oe_val, "OE readback");
		@(posedge clk);
		io_in <= pad_val;
		gpio_read(1'b1, `EXPERIAR_GPIO_IN, pad_val, "IN readback");

		// Interrupts on pad 3 only
		@(posedge clk);
		io_in <= '0;
		gpio_write(1'b0, `EXPERIAR_GPIO_IRQ_EN, 32'h8);
		gpio_read(1'b0, `EXPERIAR_GPIO_IRQ_STAT, 32'h0, "status before any edge");
		check_value(32'(irq), 32'd0, "irq_o before any edge");
		@(posedge clk);
		io_in <= 32'h20;
		gpio_read(1'b1, `EXPERIAR_GPIO_IRQ_STAT, 32'h0, "status after disabled pad edge");
		check_value(32'(irq), 32'd0, "irq_o after disabled pad edge");
		@(posedge clk);
		io_in <= 32'h28;
		wait_irq_high();
		gpio_read(1'b0, `EXPERIAR_GPIO_IRQ_STAT, 32'h8, "status after enabled pad edge");
		gpio_write(1'b1, `EXPERIAR_GPIO_IRQ_STAT, 32'h8);
		check_value(32'(irq), 32'd0, "irq_o after status clear");
		gpio_read(1'b0, `EXPERIAR_GPIO_IRQ_STAT, 32'h0, "status after clear");
	endtask

	initial begin
		rst_n <= 1'b0;
		master0_req <= '0;
		master1_req <= '0;
		io_in <= '0;
		void'($urandom(32'h9aa2bc62));
		repeat (10) @(posedge clk);
		rst_n <= 1'b1;
		@(negedge clk);
		check_reset_values();
		load_table();
		run_table();
		run_contention();
		run_periph_probe();
		run_gpio();
		// Arbiters go idle the edge after the last cyc drops
		@(posedge clk);
		@(negedge clk);
		check_value(32'(|la_data), 32'd0, "la_data_o once the bus is idle");
		$display("RESULT: PASS");
		$finish;
	end

endmodule

//--- experiar_soc.f
+incdir+rtl
rtl/experiar_pkg.sv
rtl/wb_master_port.sv
rtl/wb_slave_arbiter.sv
rtl/wb_local_memory.sv
rtl/wb_gpio.sv
rtl/experiar_soc.sv
bench/experiar_soc_tb.sv

//--- rtl/experiar_consts.svh
`ifndef EXPERIAR_CONSTS_SVH
`define EXPERIAR_CONSTS_SVH

// Bus widths
`define EXPERIAR_WB_DATA_WIDTH 32
`define EXPERIAR_WB_ADR_WIDTH 28
`define EXPERIAR_WB_SLAVE_ADR_WIDTH 24

// Local memory holds 512 words
`define EXPERIAR_SRAM_ADDRESS_SIZE 9

// One register covers every pad
`define EXPERIAR_GPIO_WIDTH 32

// Region numbers in master address bits 27..24
`define EXPERIAR_SLAVE_MEMORY 4'h0
`define EXPERIAR_SLAVE_PERIPH 4'h1

// Peripheral register word offsets
`define EXPERIAR_GPIO_OUT 0
`define EXPERIAR_GPIO_OE 1
`define EXPERIAR_GPIO_IN 2
`define EXPERIAR_GPIO_IRQ_EN 3
`define EXPERIAR_GPIO_IRQ_STAT 4

`endif

//--- rtl/experiar_pkg.sv
`include "experiar_consts.svh"

package experiar_pkg;

	typedef logic [`EXPERIAR_WB_DATA_WIDTH-1:0] wb_data_t;
	typedef logic [`EXPERIAR_WB_DATA_WIDTH/8-1:0] wb_sel_t;
	typedef logic [`EXPERIAR_WB_ADR_WIDTH-1:0] wb_adr_t;
	typedef logic [`EXPERIAR_WB_SLAVE_ADR_WIDTH-1:0] wb_slave_adr_t;
	typedef logic [`EXPERIAR_SRAM_ADDRESS_SIZE-1:0] sram_addr_t;
	typedef logic [`EXPERIAR_GPIO_WIDTH-1:0] gpio_t;

	// Request as driven by a master
	typedef struct packed {
		logic cyc;
		logic stb;
		logic we;
		wb_sel_t sel;
		wb_data_t data;
		wb_adr_t adr;
	} wb_req_t;

	// Request after the region bits are stripped
	typedef struct packed {
		logic cyc;
		logic stb;
		logic we;
		wb_sel_t sel;
		wb_data_t data;
		wb_slave_adr_t adr;
	} wb_slave_req_t;

	typedef struct packed {
		logic ack;
		logic stall;
		logic error;
		wb_data_t data;
	} wb_rsp_t;

	// Encoding doubles as the probe code of the holding master
	typedef enum logic [1:0] {
		ARB_IDLE = 2'd0,
		ARB_MASTER0 = 2'd1,
		ARB_MASTER1 = 2'd2
	} arb_state_e;

	// 0 none, 1 memory or master 0, 2 peripherals or master 1
	typedef logic [1:0] probe_t;

endpackage

//--- rtl/experiar_soc.sv
`timescale 1ns/1ps
`include "experiar_consts.svh"

module experiar_soc import experiar_pkg::*; (
		input logic wb_clk_i,
		input logic rst_n_i,

		// Master 0 is the management bus, master 1 the external port
		input wb_req_t master0_req_i,
		input wb_req_t master1_req_i,
		output wb_rsp_t master0_rsp_o,
		output wb_rsp_t master1_rsp_o,

		input gpio_t io_i,
		output gpio_t io_o,
		output gpio_t io_oeb_o,
		output logic irq_o,

		output logic [127:0] la_data_o
	);

	logic m0_mem_req, m0_periph_req;
	logic m1_mem_req, m1_periph_req;
	wb_slave_req_t m0_slave_req, m1_slave_req;
	wb_slave_req_t mem_req, periph_req;
	wb_rsp_t mem_rsp, periph_rsp;
	wb_rsp_t m0_mem_rsp, m0_periph_rsp;
	wb_rsp_t m1_mem_rsp, m1_periph_rsp;
	probe_t probe_m0_slave, probe_m1_slave;
	probe_t probe_mem_master, probe_periph_master;

	wb_master_port master0_port_i (
		.wb_clk_i(wb_clk_i), .rst_n_i(rst_n_i),
		.master_req_i(master0_req_i), .master_rsp_o(master0_rsp_o),
		.mem_req_o(m0_mem_req), .periph_req_o(m0_periph_req), .slave_req_o(m0_slave_req),
		.mem_rsp_i(m0_mem_rsp), .periph_rsp_i(m0_periph_rsp),
		.current_slave_o(probe_m0_slave));

	wb_master_port master1_port_i (
		.wb_clk_i(wb_clk_i), .rst_n_i(rst_n_i),
		.master_req_i(master1_req_i), .master_rsp_o(master1_rsp_o),
		.mem_req_o(m1_mem_req), .periph_req_o(m1_periph_req), .slave_req_o(m1_slave_req),
		.mem_rsp_i(m1_mem_rsp), .periph_rsp_i(m1_periph_rsp),
		.current_slave_o(probe_m1_slave));

	wb_slave_arbiter mem_arbiter_i (
		.wb_clk_i(wb_clk_i), .rst_n_i(rst_n_i),
		.req0_i(m0_mem_req), .req1_i(m1_mem_req),
		.port0_req_i(m0_slave_req), .port1_req_i(m1_slave_req),
		.slave_req_o(mem_req), .slave_rsp_i(mem_rsp),
		.port0_rsp_o(m0_mem_rsp), .port1_rsp_o(m1_mem_rsp),
		.current_master_o(probe_mem_master));

	wb_slave_arbiter periph_arbiter_i (
		.wb_clk_i(wb_clk_i), .rst_n_i(rst_n_i),
		.req0_i(m0_periph_req), .req1_i(m1_periph_req),
		.port0_req_i(m0_slave_req), .port1_req_i(m1_slave_req),
		.slave_req_o(periph_req), .slave_rsp_i(periph_rsp),
		.port0_rsp_o(m0_periph_rsp), .port1_rsp_o(m1_periph_rsp),
		.current_master_o(probe_periph_master));

	wb_local_memory local_memory_i (
		.wb_clk_i(wb_clk_i), .rst_n_i(rst_n_i),
		.req_i(mem_req), .rsp_o(mem_rsp));

	wb_gpio gpio_i (
		.wb_clk_i(wb_clk_i), .rst_n_i(rst_n_i),
		.req_i(periph_req), .rsp_o(periph_rsp),
		.io_i(io_i), .io_o(io_o), .io_oeb_o(io_oeb_o),
		.irq_o(irq_o));

	// Interconnect probes in the low byte
	assign la_data_o = {
		120'b0,
		probe_periph_master,
		probe_mem_master,
		probe_m1_slave,
		probe_m0_slave
	};

endmodule

//--- rtl/wb_gpio.sv
`timescale 1ns/1ps
`include "experiar_consts.svh"

module wb_gpio import experiar_pkg::*; (
		input logic wb_clk_i,
		input logic rst_n_i,

		input wb_slave_req_t req_i,
		output wb_rsp_t rsp_o,

		// Pads
		input gpio_t io_i,
		output gpio_t io_o,
		output gpio_t io_oeb_o,

		output logic irq_o
	);

	logic [`EXPERIAR_WB_SLAVE_ADR_WIDTH-3:0] word_offset;
	logic offset_valid;
	logic accept;
	logic ack_q;
	logic err_q;
	wb_data_t rdata_q;
	wb_data_t read_word;
	gpio_t out_q;
	gpio_t oeb_q;
	gpio_t in_q;
	gpio_t in_prev_q;
	gpio_t irq_en_q;
	gpio_t irq_stat_q;
	gpio_t rising;

	assign word_offset = req_i.adr[`EXPERIAR_WB_SLAVE_ADR_WIDTH-1:2];
	assign offset_valid = (word_offset <= `EXPERIAR_GPIO_IRQ_STAT);
	assign accept = req_i.cyc && req_i.stb && !ack_q && !err_q;

	// Edge seen on the synchronized pad value
	assign rising = in_q & ~in_prev_q;

	always_comb begin
		case (word_offset)
			`EXPERIAR_GPIO_OUT: read_word = out_q;
			`EXPERIAR_GPIO_OE: read_word = oeb_q;
			`EXPERIAR_GPIO_IN: read_word = in_q;
			`EXPERIAR_GPIO_IRQ_EN: read_word = irq_en_q;
			`EXPERIAR_GPIO_IRQ_STAT: read_word = irq_stat_q;
			default: read_word = '0;
		endcase
	end

	always_ff @(posedge wb_clk_i) begin
		if (!rst_n_i) begin
			ack_q <= 1'b0;
			err_q <= 1'b0;
			out_q <= '0;
			oeb_q <= '1;
			in_q <= '0;
			in_prev_q <= '0;
			irq_en_q <= '0;
			irq_stat_q <= '0;
		end else begin
			in_q <= io_i;
			in_prev_q <= in_q;
			ack_q <= accept && offset_valid;
			err_q <= accept && !offset_valid;
			irq_stat_q <= irq_stat_q | (rising & irq_en_q);
			// Full-word writes, sel is ignored
			if (accept && offset_valid && req_i.we) begin
				case (word_offset)
					`EXPERIAR_GPIO_OUT: out_q <= req_i.data;
					`EXPERIAR_GPIO_OE: oeb_q <= req_i.data;
					`EXPERIAR_GPIO_IRQ_EN: irq_en_q <= req_i.data;
					// New edges win over a clear in the same cycle
					`EXPERIAR_GPIO_IRQ_STAT: irq_stat_q <= (irq_stat_q & ~req_i.data) | (rising & irq_en_q);
					default: ;
				endcase
			end
		end
	end

	always_ff @(posedge wb_clk_i) begin
		if (accept) rdata_q <= read_word;
	end

	assign rsp_o.ack = ack_q;
	assign rsp_o.stall = 1'b0;
	assign rsp_o.error = err_q;
	assign rsp_o.data = rdata_q;

	assign io_o = out_q;
	assign io_oeb_o = oeb_q;
	assign irq_o = |irq_stat_q;

endmodule

//--- rtl/wb_local_memory.sv
`timescale 1ns/1ps
`include "experiar_consts.svh"

module wb_local_memory import experiar_pkg::*; (
		input logic wb_clk_i,
		input logic rst_n_i,

		input wb_slave_req_t req_i,
		output wb_rsp_t rsp_o
	);

	localparam int WORDS = 1 << `EXPERIAR_SRAM_ADDRESS_SIZE;

	wb_data_t mem [0:WORDS-1];
	wb_data_t rdata_q;
	sram_addr_t word_index;
	logic ack_q;
	logic accept;

	// Bits above 10 alias onto the same word
	assign word_index = req_i.adr[`EXPERIAR_SRAM_ADDRESS_SIZE+1:2];

	// The strobe is still up during the ack cycle, so it must not count twice
	assign accept = req_i.cyc && req_i.stb && !ack_q;

	always_ff @(posedge wb_clk_i) begin
		if (!rst_n_i) begin
			ack_q <= 1'b0;
		end else begin
			ack_q <= accept;
		end
	end

	always_ff @(posedge wb_clk_i) begin
		if (accept) begin
			rdata_q <= mem[word_index];
			if (req_i.we) begin
				for (int i = 0; i < `EXPERIAR_WB_DATA_WIDTH / 8; i++) begin
					if (req_i.sel[i]) mem[word_index][8*i +: 8] <= req_i.data[8*i +: 8];
				end
			end
		end
	end

	assign rsp_o.ack = ack_q;
	assign rsp_o.stall = 1'b0;
	assign rsp_o.error = 1'b0;
	assign rsp_o.data = rdata_q;

endmodule

//--- rtl/wb_master_port.sv
`timescale 1ns/1ps
`include "experiar_consts.svh"

module wb_master_port import experiar_pkg::*; (
		input logic wb_clk_i,
		input logic rst_n_i,

		// Master side
		input wb_req_t master_req_i,
		output wb_rsp_t master_rsp_o,

		// Toward the arbiters
		output logic mem_req_o,
		output logic periph_req_o,
		output wb_slave_req_t slave_req_o,
		input wb_rsp_t mem_rsp_i,
		input wb_rsp_t periph_rsp_i,

		output probe_t current_slave_o
	);

	logic [`EXPERIAR_WB_ADR_WIDTH-`EXPERIAR_WB_SLAVE_ADR_WIDTH-1:0] region;
	logic is_mem;
	logic is_periph;
	logic unmapped_err_q;

	assign region = master_req_i.adr[`EXPERIAR_WB_ADR_WIDTH-1:`EXPERIAR_WB_SLAVE_ADR_WIDTH];
	assign is_mem = (region == `EXPERIAR_SLAVE_MEMORY);
	assign is_periph = (region == `EXPERIAR_SLAVE_PERIPH);

	// Request line stays up for the whole cycle so the arbiter keeps the grant
	assign mem_req_o = master_req_i.cyc && is_mem;
	assign periph_req_o = master_req_i.cyc && is_periph;

	assign slave_req_o.cyc = master_req_i.cyc;
	assign slave_req_o.stb = master_req_i.stb;
	assign slave_req_o.we = master_req_i.we;
	assign slave_req_o.sel = master_req_i.sel;
	assign slave_req_o.data = master_req_i.data;
	assign slave_req_o.adr = master_req_i.adr[`EXPERIAR_WB_SLAVE_ADR_WIDTH-1:0];

	// One-cycle error pulse for a strobe outside both regions
	always_ff @(posedge wb_clk_i) begin
		if (!rst_n_i) begin
			unmapped_err_q <= 1'b0;
		end else begin
			unmapped_err_q <= master_req_i.cyc && master_req_i.stb && !is_mem && !is_periph
				&& !unmapped_err_q;
		end
	end

	always_comb begin
		master_rsp_o = '0;
		if (is_mem) begin
			master_rsp_o = mem_rsp_i;
		end else if (is_periph) begin
			master_rsp_o = periph_rsp_i;
		end
		master_rsp_o.error = master_rsp_o.error | unmapped_err_q;
	end

	always_comb begin
		current_slave_o = 2'd0;
		if (master_req_i.cyc && is_mem) begin
			current_slave_o = 2'd1;
		end else if (master_req_i.cyc && is_periph) begin
			current_slave_o = 2'd2;
		end
	end

endmodule

//--- rtl/wb_slave_arbiter.sv
`timescale 1ns/1ps
`include "experiar_consts.svh"

module wb_slave_arbiter import experiar_pkg::*; (
		input logic wb_clk_i,
		input logic rst_n_i,

		input logic req0_i,
		input logic req1_i,
		input wb_slave_req_t port0_req_i,
		input wb_slave_req_t port1_req_i,

		output wb_slave_req_t slave_req_o,
		input wb_rsp_t slave_rsp_i,

		output wb_rsp_t port0_rsp_o,
		output wb_rsp_t port1_rsp_o,

		output probe_t current_master_o
	);

	arb_state_e state_q;
	arb_state_e state_d;
	logic grant0;
	logic grant1;

	// Fixed priority, master 0 wins a tie
	always_comb begin
		state_d = state_q;
		case (state_q)
			ARB_IDLE: begin
				if (req0_i) begin
					state_d = ARB_MASTER0;
				end else if (req1_i) begin
					state_d = ARB_MASTER1;
				end
			end
			ARB_MASTER0: if (!req0_i) state_d = ARB_IDLE;
			ARB_MASTER1: if (!req1_i) state_d = ARB_IDLE;
			default: state_d = ARB_IDLE;
		endcase
	end

	always_ff @(posedge wb_clk_i) begin
		if (!rst_n_i) begin
			state_q <= ARB_IDLE;
		end else begin
			state_q <= state_d;
		end
	end

	// Gate with the request so a master's strobe toward the other slave never leaks here
	assign grant0 = (state_q == ARB_MASTER0) && req0_i;
	assign grant1 = (state_q == ARB_MASTER1) && req1_i;

	always_comb begin
		slave_req_o = '0;
		if (grant0) begin
			slave_req_o = port0_req_i;
		end else if (grant1) begin
			slave_req_o = port1_req_i;
		end
	end

	// A waiting master sees stall until it holds the slave
	always_comb begin
		port0_rsp_o = '0;
		port1_rsp_o = '0;
		if (grant0) begin
			port0_rsp_o = slave_rsp_i;
		end else begin
			port0_rsp_o.stall = req0_i;
		end
		if (grant1) begin
			port1_rsp_o = slave_rsp_i;
		end else begin
			port1_rsp_o.stall = req1_i;
		end
	end

	assign current_master_o = probe_t'(state_q);

endmodule

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the experiar_soc testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary -Wno-fatal --top-module experiar_soc_tb \
	-f experiar_soc.f -Mdir obj_dir
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

output="$(./obj_dir/Vexperiar_soc_tb 2>&1)"
status=$?
echo "$output"

if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if echo "$output" | grep -q "^RESULT: PASS$"; then
	exit 0
fi
exit 1
